/* sim.f */
rtl/PathBufPkg.sv
rtl/BurstCounter.sv
rtl/PathBuffer.sv
rtl/EncStageQueue.sv
rtl/PortArbiter.sv
rtl/PathBufferTop.sv
test/PathBufferTb.sv

/* Makefile */
.PHONY: sim clean

sim:
	verilator --binary --timing --timescale 1ns/1ps --top-module PathBufferTb -f sim.f -Mdir obj_dir
	out=$$(./obj_dir/VPathBufferTb); echo "$$out"; echo "$$out" | grep -qx "No errors"

clean:
	rm -rf obj_dir

/* test/PathBufferTb.sv */
/*
 * Testbench of the ORAM path buffer. Runs a table of fill and drain phases
 * and checks the encryptor output against a scoreboard.
 */

module PathBufferTb;
	timeunit 1ns;
	timeprecision 100ps;

	localparam logic [1:0] RO = 2'd1;
	localparam logic [1:0] RW = 2'd2;
	localparam int NumPhases = 14;

	typedef struct packed {
		logic [1:0] mode;
		logic wb; // writeback, else read
		logic [7:0] bursts;
		logic [7:0] gaps; // strobe gap pattern, bit set means idle cycle
		logic [1:0] takeMode; // 0 random, 1 long stalls
		logic [7:0] ivLow; // drain cycles with IvReady low
		logic [7:0] abortAfter; // reset after this many pops, 0 never
	} PhaseT;

	logic Clock;
	logic rst;
	PathBufPkg::AccessModeT AccessMode;
	logic PathRead;
	logic PathWriteback;
	logic DecValid;
	PathBufPkg::DataT DecData;
	logic StashValid;
	PathBufPkg::DataT StashData;
	logic HeaderValid;
	PathBufPkg::DataT HeaderData;
	logic IvReady;
	logic EncTake;
	PathBufPkg::EncOutT EncOut;
	logic PathDone;
	logic HeaderDone;

	PhaseT phases [NumPhases];
	PathBufPkg::DataT pathQ [$];
	PathBufPkg::DataT hdrQ [$];
	PathBufPkg::DataT expQ [$];
	logic [31:0] seed = 32'd88;
	int errorCount = 0;
	int pathDones = 0;
	int hdrDones = 0;
	logic prevValid = 1'b0;
	logic prevTake = 1'b0;
	PathBufPkg::DataT prevData;

	PathBufferTop #(.OramLevels(3), .BktBursts(4)) u_PathBufferTop (.*);

	initial begin
		Clock = 1'b0;
		forever #4 Clock = ~Clock;
	end

	always @(posedge Clock) begin
		if (!rst) begin
			if (PathDone) pathDones++;
			if (HeaderDone) hdrDones++;
		end
	end

	// ==============================
	// helpers
	// ==============================

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1103515245 + 32'd12345; // LCG step
		return seed;
	endfunction

	task automatic failRun(input string why);
		errorCount++;
		$display("%s", why);
		$display("Errors found");
		$fatal(1, "stopped at first error");
	endtask

	task automatic checkEq(input string name, input logic [63:0] got, input logic [63:0] exp);
		if (got !== exp) begin
			failRun($sformatf("CHECK FAILED at %0t ns: %s is %h, expected %h",
				$time, name, got, exp));
		end
	endtask

	// one negedge: sample the queue head, then drive EncTake
	task automatic cycleStep(input logic take);
		logic valid;
		PathBufPkg::DataT data;
		PathBufPkg::DataT exp;
		@(negedge Clock);
		valid = EncOut.Valid;
		data = EncOut.Data;
		if (prevValid && !prevTake) begin // stalled head must hold
			checkEq("EncOut.Valid", 64'(valid), 64'(1));
			checkEq("EncOut.Data", data, prevData);
		end
		EncTake = take;
		if (take && valid) begin
			if (expQ.size() == 0) begin
				failRun($sformatf("Unexpected extra burst on EncOut at %0t ns", $time));
			end
			exp = expQ.pop_front();
			checkEq("EncOut.Data", data, exp);
		end
		prevValid = valid;
		prevTake = take;
		prevData = data;
	endtask

	task automatic clearInputs();
		AccessMode = PathBufPkg::ModeIdle;
		PathRead = 1'b0;
		PathWriteback = 1'b0;
		DecValid = 1'b0;
		StashValid = 1'b0;
		HeaderValid = 1'b0;
		IvReady = 1'b1;
		EncTake = 1'b0;
	endtask

	task automatic applyReset();
		rst = 1'b1;
		clearInputs();
		repeat (5) @(negedge Clock);
		checkEq("EncOut.Valid", 64'(EncOut.Valid), 64'(0));
		rst = 1'b0;
		prevValid = 1'b0;
		prevTake = 1'b0;
		pathQ.delete();
		hdrQ.delete();
		expQ.delete();
	endtask

	task automatic driveSource(input PhaseT p, input logic valid, input PathBufPkg::DataT d);
		DecValid = (p.mode == RW) && !p.wb && valid;
		StashValid = (p.mode == RW) && p.wb && valid;
		HeaderValid = (p.mode == RO) && valid;
		// idle sources carry other data, a wrong write source shows up
		DecData = DecValid ? d : ~d;
		StashData = StashValid ? d : ~d;
		HeaderData = HeaderValid ? d : ~d;
	endtask

	// ==============================
	// one table phase
	// ==============================

	task automatic runPhase(input PhaseT p);
		int bursts;
		int n;
		int c;
		int popped;
		int pathStart;
		int hdrStart;
		logic take;
		logic [31:0] r;
		PathBufPkg::DataT d;
		bursts = int'(p.bursts);
		pathStart = pathDones;
		hdrStart = hdrDones;
		AccessMode = PathBufPkg::AccessModeT'(p.mode);
		PathRead = !p.wb;
		PathWriteback = p.wb;
		IvReady = (p.ivLow == 8'd0);
		n = 0;
		c = 0;
		// fill part, RO writeback has none
		while (n < bursts && !(p.mode == RO && p.wb)) begin
			cycleStep(1'b0);
			// no done pulse before the last strobe
			checkEq("PathDone count", 64'(pathDones - pathStart), 64'(0));
			checkEq("HeaderDone count", 64'(hdrDones - hdrStart), 64'(0));
			if (p.gaps[c % 8]) begin
				driveSource(p, 1'b0, '0);
			end else begin
				d = {nextRand(), nextRand()};
				driveSource(p, 1'b1, d);
				if (p.mode == RW && p.wb) pathQ.push_back(d);
				if (p.mode == RO) hdrQ.push_back(d);
				n++;
			end
			if (!p.wb) checkEq("EncOut.Valid", 64'(EncOut.Valid), 64'(0));
			c++;
		end
		if (!(p.mode == RO && p.wb)) begin
			cycleStep(1'b0);
			driveSource(p, 1'b0, '0);
			checkEq("PathDone count", 64'(pathDones - pathStart), 64'(p.mode == RW));
			checkEq("HeaderDone count", 64'(hdrDones - hdrStart), 64'(p.mode == RO));
		end
		if (p.wb) begin
			if (p.mode == RW) begin
				expQ = pathQ;
				pathQ.delete();
			end else begin
				expQ = hdrQ;
				hdrQ.delete();
			end
			popped = 0;
			c = 0;
			while (expQ.size() > 0) begin
				r = nextRand();
				if (c < int'(p.ivLow)) take = 1'b1;
				else if (p.takeMode == 2'd1) take = (c % 24) >= 18;
				else take = r[16];
				popped = bursts - expQ.size();
				cycleStep(take);
				if (c < int'(p.ivLow)) checkEq("EncOut.Valid", 64'(EncOut.Valid), 64'(0));
				IvReady = (c + 1 >= int'(p.ivLow));
				if (p.abortAfter != 8'd0 && popped >= int'(p.abortAfter)) begin
					applyReset();
					return;
				end
				c++;
			end
			cycleStep(1'b0);
			// nothing left behind the last expected burst
			checkEq("EncOut.Valid", 64'(EncOut.Valid), 64'(0));
			checkEq("PathDone count", 64'(pathDones - pathStart), 64'((p.mode == RW) ? 2 : 0));
			checkEq("HeaderDone count", 64'(hdrDones - hdrStart), 64'((p.mode == RO) ? 1 : 0));
		end
		clearInputs();
		repeat (2) cycleStep(1'b0);
	endtask

	// ==============================
	// stimulus table
	// ==============================

	initial begin
		phases[0] = '{RW, 1'b0, 8'd16, 8'b0100_1001, 2'd0, 8'd0, 8'd0};
		phases[1] = '{RW, 1'b1, 8'd16, 8'b0010_0010, 2'd0, 8'd0, 8'd0};
		phases[2] = '{RO, 1'b0, 8'd4, 8'b0000_0101, 2'd0, 8'd0, 8'd0};
		phases[3] = '{RO, 1'b1, 8'd4, 8'b0000_0000, 2'd0, 8'd0, 8'd0};
		phases[4] = '{RW, 1'b0, 8'd16, 8'b0000_0000, 2'd0, 8'd0, 8'd0};
		phases[5] = '{RW, 1'b1, 8'd16, 8'b1000_0000, 2'd1, 8'd0, 8'd0}; // back-pressure
		phases[6] = '{RO, 1'b0, 8'd4, 8'b0000_0000, 2'd0, 8'd0, 8'd0};
		phases[7] = '{RW, 1'b0, 8'd16, 8'b0001_0000, 2'd0, 8'd0, 8'd0}; // path fill over headers
		phases[8] = '{RO, 1'b1, 8'd4, 8'b0000_0000, 2'd0, 8'd20, 8'd0};
		phases[9] = '{RW, 1'b1, 8'd16, 8'b0000_0000, 2'd0, 8'd20, 8'd0};
		phases[10] = '{RW, 1'b0, 8'd16, 8'b0000_0000, 2'd0, 8'd0, 8'd0};
		phases[11] = '{RW, 1'b1, 8'd16, 8'b0000_0000, 2'd1, 8'd0, 8'd5}; // reset mid-drain
		phases[12] = '{RW, 1'b0, 8'd16, 8'b0110_0000, 2'd0, 8'd0, 8'd0};
		phases[13] = '{RW, 1'b1, 8'd16, 8'b0000_1001, 2'd0, 8'd0, 8'd0};
	end

	// watchdog sized from the table
	initial begin
		int total;
		total = 0;
		#1;
		foreach (phases[i]) total += int'(phases[i].bursts);
		#((total * 40 + NumPhases * 60) * 8);
		$display("Timeout: the run did not finish in time, the DUT seems stuck");
		errorCount++;
		$display("Errors found");
		$fatal(1, "watchdog expired");
	end

	initial begin
		rst = 1'b1;
		clearInputs();
		DecData = '0;
		StashData = '0;
		HeaderData = '0;
		applyReset();
		foreach (phases[i]) begin
			runPhase(phases[i]);
		end
		if (errorCount == 0) begin
			$display("No errors");
		end else begin
			$display("Errors found");
		end
		$finish;
	end

endmodule

/* rtl/PathBufferTop.sv */
/*
 * ORAM path buffer subsystem. Arbiter, burst counters, path buffer
 * memory and encryptor staging queue.
 */

module PathBufferTop #(
	parameter int OramLevels = 3,
	parameter int BktBursts = 4
) (
	input logic Clock,
	input logic rst,
	input PathBufPkg::AccessModeT AccessMode,
	input logic PathRead,
	input logic PathWriteback,
	input logic DecValid,
	input PathBufPkg::DataT DecData,
	input logic StashValid,
	input PathBufPkg::DataT StashData,
	input logic HeaderValid,
	input PathBufPkg::DataT HeaderData,
	input logic IvReady,
	input logic EncTake,
	output PathBufPkg::EncOutT EncOut,
	output logic PathDone,
	output logic HeaderDone
);

	localparam int PathBursts = BktBursts * (OramLevels + 1);
	localparam int HdrWords = OramLevels + 1; // one header per bucket
	localparam int Depth = PathBursts + HdrWords;

	PathBufPkg::BufReqT bufReq;
	PathBufPkg::DataT rdData;
	PathBufPkg::CountT pathCount;
	PathBufPkg::CountT hdrCount;
	logic rdStrobe;
	logic [1:0] freeCount;
	logic pathCtrEn;
	logic hdrCtrEn;

	PortArbiter #(
		.OramLevels(OramLevels),
		.BktBursts(BktBursts)
	) arbiter (
		.Clock(Clock),
		.rst(rst),
		.AccessMode(AccessMode),
		.PathRead(PathRead),
		.PathWriteback(PathWriteback),
		.DecValid(DecValid),
		.DecData(DecData),
		.StashValid(StashValid),
		.StashData(StashData),
		.HeaderValid(HeaderValid),
		.HeaderData(HeaderData),
		.IvReady(IvReady),
		.FreeCount(freeCount),
		.PathCount(pathCount),
		.PathLast(PathDone),
		.HdrCount(hdrCount),
		.HdrLast(HeaderDone),
		.PathCtrEn(pathCtrEn),
		.HdrCtrEn(hdrCtrEn),
		.BufReq(bufReq),
		.RdStrobe(rdStrobe)
	);

	BurstCounter #(.Threshold(PathBursts)) pathCtr (
		.Clock(Clock),
		.rst(rst),
		.Enable(pathCtrEn),
		.Count(pathCount),
		.Done(PathDone)
	);

	BurstCounter #(.Threshold(HdrWords)) hdrCtr (
		.Clock(Clock),
		.rst(rst),
		.Enable(hdrCtrEn),
		.Count(hdrCount),
		.Done(HeaderDone)
	);

	PathBuffer #(.Depth(Depth)) buffer (
		.Clock(Clock),
		.BufReq(bufReq),
		.RdData(rdData)
	);

	EncStageQueue stageQueue (
		.Clock(Clock),
		.rst(rst),
		.RdStrobe(rdStrobe),
		.RdData(rdData),
		.EncTake(EncTake),
		.EncOut(EncOut),
		.FreeCount(freeCount)
	);

endmodule

/* rtl/PortArbiter.sv */
/*
 * Port arbiter of the path buffer. Grants the single buffer port to the
 * decryptor, stash or header source during fills, or to drain reads paced
 * against the staging queue during writebacks.
 */

module PortArbiter #(
	parameter int OramLevels = 3,
	parameter int BktBursts = 4
) (
	input logic Clock,
	input logic rst,
	input PathBufPkg::AccessModeT AccessMode,
	input logic PathRead,
	input logic PathWriteback,
	input logic DecValid,
	input PathBufPkg::DataT DecData,
	input logic StashValid,
	input PathBufPkg::DataT StashData,
	input logic HeaderValid,
	input PathBufPkg::DataT HeaderData,
	input logic IvReady,
	input logic [1:0] FreeCount,
	input PathBufPkg::CountT PathCount,
	input logic PathLast,
	input PathBufPkg::CountT HdrCount,
	input logic HdrLast,
	output logic PathCtrEn,
	output logic HdrCtrEn,
	output PathBufPkg::BufReqT BufReq,
	output logic RdStrobe
);

	localparam int PathBursts = BktBursts * (OramLevels + 1);
	localparam PathBufPkg::AddrT HdrBase = PathBufPkg::AddrT'(PathBursts);

	PathBufPkg::DirT pathDir;
	PathBufPkg::DirT hdrDir;
	logic isRW;
	logic isRO;
	logic fillGrant;
	logic drainWanted;
	logic roomForRead;
	logic drainGrant;

	assign isRW = (AccessMode == PathBufPkg::ModeRW);
	assign isRO = (AccessMode == PathBufPkg::ModeRO);

	// ==============================
	// fill and drain grants
	// ==============================

	// sources own the port in fill phases, never stalled
	always_comb begin
		fillGrant = 1'b0;
		if (isRW && PathRead) begin
			fillGrant = DecValid;
		end else if (isRW && PathWriteback && pathDir == PathBufPkg::DirFill) begin
			fillGrant = StashValid;
		end else if (isRO && PathRead) begin
			fillGrant = HeaderValid;
		end
	end

	assign drainWanted = PathWriteback &&
		((isRW && pathDir == PathBufPkg::DirDrain) ||
		(isRO && hdrDir == PathBufPkg::DirDrain));

	// a read already in flight still needs its own slot
	assign roomForRead = (FreeCount > {1'b0, RdStrobe});
	assign drainGrant = drainWanted && IvReady && roomForRead;

	assign PathCtrEn = isRW && (fillGrant || drainGrant);
	assign HdrCtrEn = isRO && (fillGrant || drainGrant);

	// ==============================
	// buffer request
	// ==============================

	always_comb begin
		BufReq.Enable = fillGrant || drainGrant;
		BufReq.Write = fillGrant;

		if (isRW) begin
			BufReq.Addr = PathCount; // path region starts at 0
		end else if (isRO) begin
			BufReq.Addr = HdrBase + HdrCount;
		end else begin
			BufReq.Addr = '0;
		end

		if (isRW && PathRead) begin
			BufReq.WrData = DecData;
		end else if (isRW) begin
			BufReq.WrData = StashData;
		end else if (isRO) begin
			BufReq.WrData = HeaderData;
		end else begin
			BufReq.WrData = '0;
		end
	end

	// ==============================
	// direction state and read strobe
	// ==============================

	// RW read phase leaves the path direction alone
	always_ff @(posedge Clock) begin
		if (rst) begin
			pathDir <= PathBufPkg::DirFill;
		end else if (isRW && PathWriteback && PathLast) begin
			pathDir <= (pathDir == PathBufPkg::DirFill) ? PathBufPkg::DirDrain
				: PathBufPkg::DirFill;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			hdrDir <= PathBufPkg::DirFill;
		end else if (HdrLast) begin
			hdrDir <= (hdrDir == PathBufPkg::DirFill) ? PathBufPkg::DirDrain
				: PathBufPkg::DirFill;
		end
	end

	always_ff @(posedge Clock) begin
		if (rst) begin
			RdStrobe <= 1'b0;
		end else begin
			RdStrobe <= drainGrant; // lines up with RdData from the buffer
		end
	end

endmodule

/* rtl/EncStageQueue.sv */
/*
 * Encryptor staging queue. Two entries that catch buffer read data,
 * present the head to the encryptor and report free room to the arbiter.
 */

module EncStageQueue (
	input logic Clock,
	input logic rst,
	input logic RdStrobe,
	input PathBufPkg::DataT RdData,
	input logic EncTake,
	output PathBufPkg::EncOutT EncOut,
	output logic [1:0] FreeCount
);

	PathBufPkg::DataT headData;
	PathBufPkg::DataT tailData;
	logic [1:0] used; // 0, 1 or 2 entries
	logic push;
	logic pop;

	assign push = RdStrobe;
	assign pop = EncTake && (used != 2'd0); // take on empty is ignored

	assign EncOut.Valid = (used != 2'd0);
	assign EncOut.Data = headData;
	assign FreeCount = 2'd2 - used;

	// ==============================
	// occupancy
	// ==============================

	always_ff @(posedge Clock) begin
		if (rst) begin
			used <= 2'd0;
		end else if (push && !pop) begin
			used <= used + 2'd1;
		end else if (pop && !push) begin
			used <= used - 2'd1;
		end
	end

	// ==============================
	// entry data
	// ==============================

	always_ff @(posedge Clock) begin
		if (pop) begin
			if (used == 2'd2) begin
				headData <= tailData; // tail moves up
				if (push) begin
					tailData <= RdData;
				end
			end else if (push) begin
				headData <= RdData; // single entry replaced in place
			end
		end else if (push) begin
			if (used == 2'd0) begin
				headData <= RdData;
			end else begin
				tailData <= RdData; // arbiter never pushes into a full queue
			end
		end
	end

endmodule

/* rtl/PathBuffer.sv */
/*
 * Path buffer memory. Single port, synchronous write, registered read.
 * Holds the path region followed by the bucket headers.
 */

module PathBuffer #(
	parameter int Depth = 20
) (
	input logic Clock,
	input PathBufPkg::BufReqT BufReq,
	output PathBufPkg::DataT RdData
);

	localparam int IdxWidth = (Depth > 1) ? $clog2(Depth) : 1;

	PathBufPkg::DataT mem [Depth];
	logic [IdxWidth-1:0] wordIdx;

	assign wordIdx = BufReq.Addr[IdxWidth-1:0]; // arbiter keeps Addr below Depth

	// one access per cycle, the arbiter owns the port
	always_ff @(posedge Clock) begin
		if (BufReq.Enable) begin
			if (BufReq.Write) begin
				mem[wordIdx] <= BufReq.WrData;
			end else begin
				RdData <= mem[wordIdx]; // valid the cycle after the grant
			end
		end
	end

endmodule

/* rtl/BurstCounter.sv */
/*
 * Burst counter. Advances on Enable, wraps after Threshold-1 and
 * flags the last count combinationally on Done.
 */

module BurstCounter #(
	parameter int Threshold = 4
) (
	input logic Clock,
	input logic rst,
	input logic Enable,
	output PathBufPkg::CountT Count,
	output logic Done
);

	localparam PathBufPkg::CountT LastCount = PathBufPkg::CountT'(Threshold - 1);

	// high together with the enable of the final burst of a phase
	assign Done = Enable && (Count == LastCount);

	always_ff @(posedge Clock) begin
		if (rst) begin
			Count <= '0;
		end else if (Enable) begin
			if (Done) begin
				Count <= '0; // wrap for the next phase
			end else begin
				Count <= Count + PathBufPkg::CountT'(1);
			end
		end
	end

endmodule

/* rtl/PathBufPkg.sv */
/*
 * Path buffer package. Shared widths, the access and direction encodings
 * and the port structs of the ORAM path buffer subsystem.
 */

package PathBufPkg;

	// ==============================
	// widths with a meaning
	// ==============================

	typedef logic [63:0] DataT; // one DRAM burst, payload or header
	typedef logic [7:0] AddrT; // buffer word address, 256 words max
	typedef logic [7:0] CountT; // burst counter value

	// ==============================
	// encodings
	// ==============================

	typedef enum logic [1:0] {
		ModeIdle,
		ModeRO,
		ModeRW
	} AccessModeT;

	typedef enum logic {
		DirFill, // sources write the buffer
		DirDrain // buffer is read toward the encryptor
	} DirT;

	// ==============================
	// port bundles
	// ==============================

	typedef struct packed {
		logic Enable;
		logic Write;
		AddrT Addr;
		DataT WrData;
	} BufReqT;

	typedef struct packed {
		logic Valid;
		DataT Data;
	} EncOutT;

endpackage
